// ==== src.f ====
+incdir+test
source/decode_pkg.sv
source/instr_match.sv
source/imm_gen.sv
source/uop_encode.sv
source/de_pipe_reg.sv
source/decode_stage.sv
test/decode_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert --timescale 1ns/1ps
TOP      = decode_tb
FILELIST = src.f
OBJ_DIR  = obj_dir
PASS_MSG = test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/decode_model.svh ====
// ---------------------------------------
// Decode reference model
// Expected micro-op and JAL target from the
// RV32I encoding rules
// ---------------------------------------
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

function automatic word_t j_imm(word_t instr);
    return {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
endfunction

// Shared funct3 table of OP and OP-IMM
function automatic alu_op_e alu_from_f3(logic [2:0] f3, logic alt);
    case (f3)
        3'd0:    return alt ? ALU_SUB : ALU_ADD;
        3'd1:    return ALU_SLL;
        3'd2:    return ALU_SLT;
        3'd3:    return ALU_SLTU;
        3'd4:    return ALU_XOR;
        3'd5:    return alt ? ALU_SRA : ALU_SRL;
        3'd6:    return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

function automatic ex_uop_t expected_uop(word_t instr, word_t pc, word_t npc,
                                         word_t rs1, word_t rs2);
    ex_uop_t    u;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm_i;
    word_t      imm_s;
    f3      = instr[14:12];
    f7      = instr[31:25];
    imm_i   = {{20{instr[31]}}, instr[31:20]};
    imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    u       = '0;                           // Unknown encodings stay NOP
    u.pc    = pc;
    u.rd    = instr[11:7];
    u.instr = instr;
    case (instr[6:0])
        7'b0110111: begin                   // LUI
            u.opr_b  = {instr[31:12], 12'h000};
            u.alu_op = ALU_OR;
        end
        7'b0010111: begin                   // AUIPC
            u.opr_a  = pc;
            u.opr_b  = {instr[31:12], 12'h000};
            u.alu_op = ALU_ADD;
        end
        7'b1101111: begin                   // JAL
            u.opr_a  = pc;
            u.opr_b  = j_imm(instr);
            u.opr_c  = npc;
            u.cfu_op = CFU_JAL;
        end
        7'b1100111: if (f3 == 3'd0) begin   // JALR
            u.opr_a  = rs1;
            u.opr_b  = imm_i;
            u.opr_c  = npc;
            u.cfu_op = CFU_JAL;
        end
        7'b1100011: if (f3 != 3'd2 && f3 != 3'd3) begin
            u.opr_a  = rs1;
            u.opr_b  = rs2;
            u.opr_c  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            u.alu_op = ALU_SUB;
            case (f3)
                3'd0:    u.cfu_op = CFU_BEQ;
                3'd1:    u.cfu_op = CFU_BNE;
                3'd4:    u.cfu_op = CFU_BLT;
                3'd5:    u.cfu_op = CFU_BGE;
                3'd6:    u.cfu_op = CFU_BLTU;
                default: u.cfu_op = CFU_BGEU;
            endcase
        end
        7'b0000011: if (f3 != 3'd3 && f3 < 3'd6) begin
            u.opr_a  = rs1;
            u.opr_b  = imm_i;
            u.alu_op = ALU_ADD;
            case (f3)
                3'd0:    u.lsu_op = LSU_LB;
                3'd1:    u.lsu_op = LSU_LH;
                3'd2:    u.lsu_op = LSU_LW;
                3'd4:    u.lsu_op = LSU_LBU;
                default: u.lsu_op = LSU_LHU;
            endcase
        end
        7'b0100011: if (f3 < 3'd3) begin
            u.opr_a  = rs1;
            u.opr_b  = imm_s;
            u.opr_c  = rs2;
            u.alu_op = ALU_ADD;
            u.lsu_op = (f3 == 3'd0) ? LSU_SB : (f3 == 3'd1) ? LSU_SH : LSU_SW;
        end
        7'b0010011: begin
            if (!((f3 == 3'd1 && f7 != 7'h00) ||
                  (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20))) begin
                u.opr_a  = rs1;
                u.opr_b  = (f3 == 3'd1 || f3 == 3'd5) ? {27'b0, instr[24:20]} : imm_i;
                u.alu_op = alu_from_f3(f3, f3 == 3'd5 && f7 == 7'h20);
            end
        end
        7'b0110011: begin
            if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                u.opr_a  = rs1;
                u.opr_b  = rs2;
                u.alu_op = alu_from_f3(f3, f7 == 7'h20);
            end
        end
        default: u.alu_op = ALU_NOP;
    endcase
    return u;
endfunction

`endif

// ==== test/decode_tb.sv ====
// ---------------------------------------
// Decode stage testbench
// Random RV32I stream with back-pressure and
// redirect acks, checked against a model
// ---------------------------------------
`timescale 1ns/1ps

module decode_tb import decode_pkg::*; ();

    `include "decode_model.svh"

    localparam int max_wait   = 64;     // Cycles per instruction before timeout
    localparam int num_instrs = 500;

    logic      g_clk;
    logic      rst_n;
    logic      s1_valid;
    word_t     s1_instr;
    word_t     s1_pc;
    word_t     s1_npc;
    logic      s1_eat;
    logic      s1_cf_valid;
    logic      s1_cf_ack;
    word_t     s1_cf_target;
    reg_addr_t s1_rs1_addr;
    reg_addr_t s1_rs2_addr;
    word_t     s1_rs1_data;
    word_t     s1_rs2_data;
    logic      s2_valid;
    logic      s2_ready;
    ex_uop_t   s2_uop;

    logic [31:0] lfsr_state;
    ex_uop_t     held_uop;      // Model of the execute register
    int          mismatches;
    int          timeouts;
    int          cycles_checked;

    decode_stage dut_i (
        .g_clk        (g_clk),
        .rst_n        (rst_n),
        .s1_valid     (s1_valid),
        .s1_instr     (s1_instr),
        .s1_pc        (s1_pc),
        .s1_npc       (s1_npc),
        .s1_eat       (s1_eat),
        .s1_cf_valid  (s1_cf_valid),
        .s1_cf_ack    (s1_cf_ack),
        .s1_cf_target (s1_cf_target),
        .s1_rs1_addr  (s1_rs1_addr),
        .s1_rs1_data  (s1_rs1_data),
        .s1_rs2_addr  (s1_rs2_addr),
        .s1_rs2_data  (s1_rs2_data),
        .s2_valid     (s2_valid),
        .s2_ready     (s2_ready),
        .s2_uop       (s2_uop)
    );

    initial g_clk = 1'b0;
    always #10 g_clk = ~g_clk;

    // ---------------------------------------
    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Mostly legal encodings, one in eight fully random
    function automatic word_t make_instr();
        word_t      w;
        int         cls;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [6:0] opc;
        w   = rand_bits(32);
        if (rand_bits(3) == 0) begin
            return w;
        end
        cls = rand_bits(4) % 9;
        f3  = w[14:12];
        f7  = w[31:25];
        case (cls)
            0:       opc = 7'b0110111;
            1:       opc = 7'b0010111;
            2:       opc = 7'b1101111;
            3: begin
                opc = 7'b1100111;
                f3  = 3'd0;
            end
            4: begin
                opc = 7'b1100011;
                if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
            end
            5: begin
                opc = 7'b0000011;
                if (f3 == 3'd3 || f3 > 3'd5) f3 = 3'd2;
            end
            6: begin
                opc = 7'b0100011;
                f3  = f3 % 3'd3;
            end
            7: begin
                opc = 7'b0010011;
                if (f3 == 3'd1 || f3 == 3'd5) f7 = (f3 == 3'd5 && w[30]) ? 7'h20 : 7'h00;
            end
            default: begin
                opc = 7'b0110011;
                f7  = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? 7'h20 : 7'h00;
            end
        endcase
        return {f7, w[24:15], f3, w[11:7], opc};
    endfunction

    task automatic report_mismatch(input string name, input string exp, input string got);
        $display("Mismatch at %0t: %s expected %s got %s", $time, name, exp, got);
        mismatches++;
    endtask

    // ---------------------------------------
    // Mid-cycle check of every DUT output
    task automatic check_cycle(output logic took);
        ex_uop_t exp_uop;
        logic    exp_cf;
        logic    exp_s2v;
        logic    exp_eat;
        word_t   exp_tgt;
        exp_cf  = s1_valid && (s1_instr[6:0] == 7'b1101111);
        exp_s2v = s1_valid && !(exp_cf && !s1_cf_ack);     // JAL waits on ack
        exp_eat = exp_s2v && s2_ready;
        exp_tgt = s1_pc + j_imm(s1_instr);
        exp_uop = expected_uop(s1_instr, s1_pc, s1_npc, s1_rs1_data, s1_rs2_data);
        cycles_checked++;
        if (s2_uop !== held_uop)
            report_mismatch("s2_uop", $sformatf("%h", held_uop), $sformatf("%h", s2_uop));
        if (s1_rs1_addr !== s1_instr[19:15])
            report_mismatch("s1_rs1_addr", $sformatf("%h", s1_instr[19:15]),
                            $sformatf("%h", s1_rs1_addr));
        if (s1_rs2_addr !== s1_instr[24:20])
            report_mismatch("s1_rs2_addr", $sformatf("%h", s1_instr[24:20]),
                            $sformatf("%h", s1_rs2_addr));
        if (s1_cf_valid !== exp_cf)
            report_mismatch("s1_cf_valid", $sformatf("%b", exp_cf), $sformatf("%b", s1_cf_valid));
        if (exp_cf && s1_cf_target !== exp_tgt)
            report_mismatch("s1_cf_target", $sformatf("%h", exp_tgt),
                            $sformatf("%h", s1_cf_target));
        if (s2_valid !== exp_s2v)
            report_mismatch("s2_valid", $sformatf("%b", exp_s2v), $sformatf("%b", s2_valid));
        if (s1_eat !== exp_eat)
            report_mismatch("s1_eat", $sformatf("%b", exp_eat), $sformatf("%b", s1_eat));
        if (exp_eat) held_uop = exp_uop;   // Visible after the next edge
        took = s1_eat;
    endtask

    task automatic drive_side_inputs();
        s1_rs1_data = rand_bits(32);
        s1_rs2_data = rand_bits(32);
        s2_ready    = rand_bits(2) != 0;
        s1_cf_ack   = rand_bits(1) != 0;
    endtask

    // Called 2 ns after a rising edge, returns at the same point
    task automatic idle_cycle();
        logic took;
        s1_valid = 1'b0;
        s1_instr = make_instr();
        drive_side_inputs();
        @(negedge g_clk);
        check_cycle(took);
        @(posedge g_clk);
        #2;
    endtask

    task automatic send_instr(input word_t instr);
        logic [31:0] r;
        logic        took;
        int          cycles;
        r        = rand_bits(30);
        s1_valid = 1'b1;
        s1_instr = instr;
        s1_pc    = {r[29:0], 2'b00};
        s1_npc   = s1_pc + 32'd4;
        took     = 1'b0;
        cycles   = 0;
        while (!took && cycles < max_wait) begin   // Fetch holds until eaten
            drive_side_inputs();
            @(negedge g_clk);
            check_cycle(took);
            @(posedge g_clk);
            #2;
            cycles++;
        end
        if (!took) begin
            $display("Timeout at %0t: instruction %h was never consumed", $time, instr);
            timeouts++;
        end
    endtask

    // ---------------------------------------
    // Main sequence
    initial begin
        int n;
        lfsr_state     = 32'h5626;
        held_uop       = '0;
        mismatches     = 0;
        timeouts       = 0;
        cycles_checked = 0;
        rst_n          = 1'b0;
        s1_valid       = 1'b0;
        s1_instr       = '0;
        s1_pc          = '0;
        s1_npc         = '0;
        s1_cf_ack      = 1'b0;
        s1_rs1_data    = '0;
        s1_rs2_data    = '0;
        s2_ready       = 1'b0;
        repeat (2) @(posedge g_clk);
        #2;
        rst_n = 1'b1;
        idle_cycle();                       // Zero payload and idle outputs
        for (n = 0; n < num_instrs; n++) begin
            if (rand_bits(2) == 0) idle_cycle();
            send_instr(make_instr());
        end
        $display("Cycles checked %0d, mismatches %0d, timeouts %0d",
                 cycles_checked, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== source/decode_stage.sv ====
// ---------------------------------------
// Decode and operand gather stage
// Top level of the RV32I decode pipeline slice
// ---------------------------------------
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic      g_clk,
    input  logic      rst_n,

    // Fetch side
    input  logic      s1_valid,
    input  word_t     s1_instr,
    input  word_t     s1_pc,
    input  word_t     s1_npc,
    output logic      s1_eat,

    // Redirect to fetch
    output logic      s1_cf_valid,
    input  logic      s1_cf_ack,
    output word_t     s1_cf_target,

    // Register file reads
    output reg_addr_t s1_rs1_addr,
    input  word_t     s1_rs1_data,
    output reg_addr_t s1_rs2_addr,
    input  word_t     s1_rs2_data,

    // Execute side
    output logic      s2_valid,
    input  logic      s2_ready,
    output ex_uop_t   s2_uop
);

    instr_kind_e kind;
    reg_addr_t   rd_addr;
    word_t       imm_b;
    word_t       imm_c;
    word_t       imm_j;
    ex_uop_t     n_uop;
    logic        is_jal;

    assign is_jal = (kind == KIND_JAL);   // Only JAL redirects at decode

    instr_match match_i (
        .instr    (s1_instr),
        .kind     (kind),
        .rs1_addr (s1_rs1_addr),
        .rs2_addr (s1_rs2_addr),
        .rd_addr  (rd_addr)
    );

    imm_gen imm_i (
        .instr (s1_instr),
        .kind  (kind),
        .imm_b (imm_b),
        .imm_c (imm_c),
        .imm_j (imm_j)
    );

    uop_encode encode_i (
        .kind     (kind),
        .instr    (s1_instr),
        .pc       (s1_pc),
        .npc      (s1_npc),
        .rs1_data (s1_rs1_data),
        .rs2_data (s1_rs2_data),
        .imm_b    (imm_b),
        .imm_c    (imm_c),
        .rd_addr  (rd_addr),
        .uop      (n_uop)
    );

    de_pipe_reg pipe_i (
        .g_clk        (g_clk),
        .rst_n        (rst_n),
        .s1_valid     (s1_valid),
        .is_jal       (is_jal),
        .jump_target  (imm_j),
        .s1_cf_ack    (s1_cf_ack),
        .s2_ready     (s2_ready),
        .n_uop        (n_uop),
        .s1_cf_valid  (s1_cf_valid),
        .s1_eat       (s1_eat),
        .s2_valid     (s2_valid),
        .s1_cf_target (s1_cf_target),
        .s2_uop       (s2_uop)
    );

endmodule

// ==== source/de_pipe_reg.sv ====
// ---------------------------------------
// Decode to execute pipeline register
// JAL redirect handshake, eat strobe and the
// registered micro-op
// ---------------------------------------
`timescale 1ns/1ps

module de_pipe_reg import decode_pkg::*; (
    input  logic    g_clk,
    input  logic    rst_n,
    input  logic    s1_valid,
    input  logic    is_jal,
    input  word_t   jump_target,     // J-immediate before adding the PC
    input  logic    s1_cf_ack,
    input  logic    s2_ready,
    input  ex_uop_t n_uop,
    output logic    s1_cf_valid,
    output logic    s1_eat,
    output logic    s2_valid,
    output word_t   s1_cf_target,
    output ex_uop_t s2_uop
);

    logic cf_wait;

    // ---------------------------------------
    // Control flow change from decode
    assign s1_cf_valid  = s1_valid && is_jal;
    assign s1_cf_target = n_uop.pc + jump_target;

    // Hold the JAL until fetch takes the redirect
    assign cf_wait = s1_cf_valid && !s1_cf_ack;

    // ---------------------------------------
    // Stage handshake
    assign s2_valid = s1_valid && !cf_wait;
    assign s1_eat   = s2_valid && s2_ready;   // High only on transfer

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            s2_uop <= '0;
        end else if (s1_eat) begin
            s2_uop <= n_uop;
        end
    end

    // ---------------------------------------
    // Checks

    // A pending redirect keeps its request and target until acked
    cf_hold_a: assert property (
        @(posedge g_clk) disable iff (!rst_n)
        cf_wait |=> s1_cf_valid && $stable(s1_cf_target)
    ) else $error("de_pipe_reg: redirect request dropped before ack");

    // Execute payload only moves on a transfer edge
    uop_hold_a: assert property (
        @(posedge g_clk) disable iff (!rst_n)
        $past(rst_n) && !$past(s1_eat) |-> $stable(s2_uop)
    ) else $error("de_pipe_reg: s2_uop changed without a transfer");

endmodule

// ==== source/uop_encode.sv ====
// ---------------------------------------
// Micro-op encoder
// Picks operand sources and builds the ALU, LSU
// and CFU ops for the execute stage
// ---------------------------------------
`timescale 1ns/1ps

module uop_encode import decode_pkg::*; (
    input  instr_kind_e kind,
    input  word_t       instr,
    input  word_t       pc,
    input  word_t       npc,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    input  word_t       imm_b,
    input  word_t       imm_c,
    input  reg_addr_t   rd_addr,
    output ex_uop_t     uop
);

    logic sel_a_rs1;
    logic sel_a_pc;
    logic sel_b_rs2;
    logic sel_b_imm;
    logic sel_c_rs2;
    logic sel_c_imm;
    logic sel_c_npc;

    alu_op_e alu_op;
    lsu_op_e lsu_op;
    cfu_op_e cfu_op;

    // ---------------------------------------
    // Operand source selects
    assign sel_a_rs1 = is_branch(kind) || is_load(kind) || is_store(kind) ||
                       is_alu_imm(kind) || is_alu_reg(kind) || kind == KIND_JALR;
    assign sel_a_pc  = kind inside {KIND_JAL, KIND_AUIPC};

    assign sel_b_rs2 = is_branch(kind) || is_alu_reg(kind);
    assign sel_b_imm = (kind != KIND_NONE) && !sel_b_rs2;

    assign sel_c_rs2 = is_store(kind);          // Store data
    assign sel_c_imm = is_branch(kind);         // Branch offset
    assign sel_c_npc = kind inside {KIND_JAL, KIND_JALR};   // Link value

    // ---------------------------------------
    // ALU op
    always_comb begin
        case (kind)
            KIND_BEQ, KIND_BNE, KIND_BLT, KIND_BGE, KIND_BLTU, KIND_BGEU,
            KIND_SUB:
                alu_op = ALU_SUB;
            KIND_AUIPC, KIND_LB, KIND_LH, KIND_LW, KIND_LBU, KIND_LHU,
            KIND_SB, KIND_SH, KIND_SW, KIND_ADDI, KIND_ADD:
                alu_op = ALU_ADD;
            KIND_LUI, KIND_ORI, KIND_OR: alu_op = ALU_OR;   // LUI is 0 | imm
            KIND_ANDI, KIND_AND:         alu_op = ALU_AND;
            KIND_XORI, KIND_XOR:         alu_op = ALU_XOR;
            KIND_SLTI, KIND_SLT:         alu_op = ALU_SLT;
            KIND_SLTIU, KIND_SLTU:       alu_op = ALU_SLTU;
            KIND_SLLI, KIND_SLL:         alu_op = ALU_SLL;
            KIND_SRLI, KIND_SRL:         alu_op = ALU_SRL;
            KIND_SRAI, KIND_SRA:         alu_op = ALU_SRA;
            default:                     alu_op = ALU_NOP;  // Jumps and unknown
        endcase
    end

    // LSU op
    always_comb begin
        case (kind)
            KIND_LB:  lsu_op = LSU_LB;
            KIND_LBU: lsu_op = LSU_LBU;
            KIND_LH:  lsu_op = LSU_LH;
            KIND_LHU: lsu_op = LSU_LHU;
            KIND_LW:  lsu_op = LSU_LW;
            KIND_SB:  lsu_op = LSU_SB;
            KIND_SH:  lsu_op = LSU_SH;
            KIND_SW:  lsu_op = LSU_SW;
            default:  lsu_op = LSU_NONE;
        endcase
    end

    // CFU op, JALR shares the JAL encoding
    always_comb begin
        case (kind)
            KIND_BEQ:            cfu_op = CFU_BEQ;
            KIND_BNE:            cfu_op = CFU_BNE;
            KIND_BLT:            cfu_op = CFU_BLT;
            KIND_BGE:            cfu_op = CFU_BGE;
            KIND_BLTU:           cfu_op = CFU_BLTU;
            KIND_BGEU:           cfu_op = CFU_BGEU;
            KIND_JAL, KIND_JALR: cfu_op = CFU_JAL;
            default:             cfu_op = CFU_NONE;
        endcase
    end

    // ---------------------------------------
    // Micro-op assembly
    always_comb begin
        uop.pc     = pc;
        uop.opr_a  = {xlen{sel_a_rs1}} & rs1_data |
                     {xlen{sel_a_pc }} & pc;
        uop.opr_b  = {xlen{sel_b_rs2}} & rs2_data |
                     {xlen{sel_b_imm}} & imm_b;
        uop.opr_c  = {xlen{sel_c_rs2}} & rs2_data |
                     {xlen{sel_c_imm}} & imm_c    |
                     {xlen{sel_c_npc}} & npc;
        uop.rd     = rd_addr;
        uop.alu_op = alu_op;
        uop.lsu_op = lsu_op;
        uop.cfu_op = cfu_op;
        uop.instr  = instr;
    end

endmodule

// ==== source/imm_gen.sv ====
// ---------------------------------------
// Immediate generator
// Sign-extended immediates for operands B and C
// and the decode-stage jump target
// ---------------------------------------
`timescale 1ns/1ps

module imm_gen import decode_pkg::*; (
    input  word_t       instr,
    input  instr_kind_e kind,
    output word_t       imm_b,
    output word_t       imm_c,
    output word_t       imm_j
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_br;
    word_t imm_u;
    word_t imm_shamt;

    // ---------------------------------------
    // Format immediates
    assign imm_i     = {{20{instr[31]}}, instr[31:20]};
    assign imm_s     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_br    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                        instr[11:8], 1'b0};
    assign imm_u     = {instr[31:12], 12'b0};
    assign imm_shamt = {27'b0, instr[24:20]};   // Zero-extended shift amount

    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    // ---------------------------------------
    // Operand B immediate
    always_comb begin
        if (kind inside {KIND_SLLI, KIND_SRLI, KIND_SRAI}) begin
            imm_b = imm_shamt;
        end else if (is_load(kind) || is_alu_imm(kind) || kind == KIND_JALR) begin
            imm_b = imm_i;
        end else if (is_store(kind)) begin
            imm_b = imm_s;
        end else if (kind inside {KIND_LUI, KIND_AUIPC}) begin
            imm_b = imm_u;
        end else if (kind == KIND_JAL) begin
            imm_b = imm_j;
        end else begin
            imm_b = '0;
        end
    end

    // Branch offset rides on operand C
    assign imm_c = is_branch(kind) ? imm_br : '0;

endmodule

// ==== source/instr_match.sv ====
// ---------------------------------------
// Instruction matcher
// Names the RV32I instruction kind from the
// opcode, funct3 and funct7 fields
// ---------------------------------------
`timescale 1ns/1ps

module instr_match import decode_pkg::*; (
    input  word_t       instr,
    output instr_kind_e kind,
    output reg_addr_t   rs1_addr,
    output reg_addr_t   rs2_addr,
    output reg_addr_t   rd_addr
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Register fields sit at fixed positions in every format
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];

    always_comb begin
        kind = KIND_NONE;   // Anything unmatched
        case (opcode)
            opc_lui:   kind = KIND_LUI;
            opc_auipc: kind = KIND_AUIPC;
            opc_jal:   kind = KIND_JAL;
            opc_jalr:  kind = (funct3 == 3'b000) ? KIND_JALR : KIND_NONE;
            opc_branch: begin
                case (funct3)
                    3'b000:  kind = KIND_BEQ;
                    3'b001:  kind = KIND_BNE;
                    3'b100:  kind = KIND_BLT;
                    3'b101:  kind = KIND_BGE;
                    3'b110:  kind = KIND_BLTU;
                    3'b111:  kind = KIND_BGEU;
                    default: kind = KIND_NONE;
                endcase
            end
            opc_load: begin
                case (funct3)
                    3'b000:  kind = KIND_LB;
                    3'b001:  kind = KIND_LH;
                    3'b010:  kind = KIND_LW;
                    3'b100:  kind = KIND_LBU;
                    3'b101:  kind = KIND_LHU;
                    default: kind = KIND_NONE;
                endcase
            end
            opc_store: begin
                case (funct3)
                    3'b000:  kind = KIND_SB;
                    3'b001:  kind = KIND_SH;
                    3'b010:  kind = KIND_SW;
                    default: kind = KIND_NONE;
                endcase
            end
            opc_op_imm: begin
                case (funct3)
                    3'b000: kind = KIND_ADDI;
                    3'b010: kind = KIND_SLTI;
                    3'b011: kind = KIND_SLTIU;
                    3'b100: kind = KIND_XORI;
                    3'b110: kind = KIND_ORI;
                    3'b111: kind = KIND_ANDI;
                    // Shifts reuse funct7 and shamt[5] must be clear on RV32
                    3'b001: kind = (funct7 == f7_zero) ? KIND_SLLI : KIND_NONE;
                    3'b101: kind = (funct7 == f7_zero) ? KIND_SRLI :
                                   (funct7 == f7_alt)  ? KIND_SRAI : KIND_NONE;
                    default: kind = KIND_NONE;
                endcase
            end
            opc_op: begin
                if (funct7 == f7_zero) begin
                    case (funct3)
                        3'b000:  kind = KIND_ADD;
                        3'b001:  kind = KIND_SLL;
                        3'b010:  kind = KIND_SLT;
                        3'b011:  kind = KIND_SLTU;
                        3'b100:  kind = KIND_XOR;
                        3'b101:  kind = KIND_SRL;
                        3'b110:  kind = KIND_OR;
                        default: kind = KIND_AND;
                    endcase
                end else if (funct7 == f7_alt) begin
                    case (funct3)
                        3'b000:  kind = KIND_SUB;
                        3'b101:  kind = KIND_SRA;
                        default: kind = KIND_NONE;
                    endcase
                end
            end
            default: kind = KIND_NONE;
        endcase
    end

endmodule

// ==== source/decode_pkg.sv ====
// ---------------------------------------
// Decode stage package
// RV32I widths, instruction kinds, micro-op
// encodings and the decode to execute payload
// ---------------------------------------
package decode_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // Major opcodes in instr[6:0]
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    localparam logic [6:0] f7_zero    = 7'b0000000;
    localparam logic [6:0] f7_alt     = 7'b0100000; // SUB and SRA/SRAI

    // Groups are kept contiguous so the range checks below work
    typedef enum logic [5:0] {
        KIND_NONE, KIND_LUI, KIND_AUIPC, KIND_JAL, KIND_JALR,
        KIND_BEQ, KIND_BNE, KIND_BLT, KIND_BGE, KIND_BLTU, KIND_BGEU,
        KIND_LB, KIND_LH, KIND_LW, KIND_LBU, KIND_LHU,
        KIND_SB, KIND_SH, KIND_SW,
        KIND_ADDI, KIND_SLTI, KIND_SLTIU, KIND_XORI, KIND_ORI, KIND_ANDI,
        KIND_SLLI, KIND_SRLI, KIND_SRAI,
        KIND_ADD, KIND_SUB, KIND_SLL, KIND_SLT, KIND_SLTU,
        KIND_XOR, KIND_SRL, KIND_SRA, KIND_OR, KIND_AND
    } instr_kind_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [3:0] {
        LSU_NONE, LSU_LB, LSU_LBU, LSU_LH, LSU_LHU, LSU_LW,
        LSU_SB, LSU_SH, LSU_SW
    } lsu_op_e;

    typedef enum logic [2:0] {
        CFU_NONE, CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE, CFU_BLTU, CFU_BGEU, CFU_JAL
    } cfu_op_e;

    // ---------------------------------------
    // Decode to execute micro-op
    typedef struct packed {
        word_t     pc;
        word_t     opr_a;
        word_t     opr_b;
        word_t     opr_c;
        reg_addr_t rd;
        alu_op_e   alu_op;
        lsu_op_e   lsu_op;
        cfu_op_e   cfu_op;
        word_t     instr;   // Raw encoding for trace
    } ex_uop_t;

    // ---------------------------------------
    // Kind group tests
    function automatic logic is_branch(instr_kind_e k);
        return k inside {[KIND_BEQ:KIND_BGEU]};
    endfunction

    function automatic logic is_load(instr_kind_e k);
        return k inside {[KIND_LB:KIND_LHU]};
    endfunction

    function automatic logic is_store(instr_kind_e k);
        return k inside {[KIND_SB:KIND_SW]};
    endfunction

    function automatic logic is_alu_imm(instr_kind_e k);
        return k inside {[KIND_ADDI:KIND_SRAI]};
    endfunction

    function automatic logic is_alu_reg(instr_kind_e k);
        return k inside {[KIND_ADD:KIND_AND]};
    endfunction

endpackage
